//--- hw/dcache_pkg.sv
/* data cache package
   geometry, size codes, state codes, address decode union and byte-enable helper */
`default_nettype none

package dcache_pkg;

  // ------------------------------
  // geometry
  // ------------------------------
  localparam int XLEN       = 32;                      // cpu word
  localparam int ADR_BITS   = 16;                      // byte address
  localparam int LINE_WORDS = 4;
  localparam int BURST_BITS = $clog2(LINE_WORDS);      // beat counter width
  localparam int SETS       = 16;
  localparam int IDX_BITS   = $clog2(SETS);
  localparam int BYTE_BITS  = 2;                       // byte within word
  localparam int OFF_BITS   = 2;                       // word within line
  localparam int TAG_BITS   = ADR_BITS - IDX_BITS - OFF_BITS - BYTE_BITS;
  localparam int LINE_BITS  = LINE_WORDS * XLEN;
  localparam int WORD_BYTES = XLEN / 8;
  localparam int LINE_BYTES = LINE_BITS / 8;

  // access size, cpu side
  localparam logic [1:0] SIZE_BYTE  = 2'd0;
  localparam logic [1:0] SIZE_HWORD = 2'd1;
  localparam logic [1:0] SIZE_WORD  = 2'd2;

  // controller states
  localparam logic [1:0] ARMED     = 2'd0;            // lookup, hit answer
  localparam logic [1:0] WRITEBACK = 2'd1;            // victim going out
  localparam logic [1:0] FILL      = 2'd2;            // line coming in
  localparam logic [1:0] RECOVER   = 2'd3;            // reread after fill

  // bus engine states
  localparam logic [1:0] IDLE     = 2'd0;
  localparam logic [1:0] WAIT4BIU = 2'd1;             // strobe held
  localparam logic [1:0] BURST    = 2'd2;

  // address seen as one word or as its fields
  typedef union packed {
    logic [ADR_BITS-1:0] raw;
    struct packed {
      logic [TAG_BITS-1:0]  tag;
      logic [IDX_BITS-1:0]  idx;
      logic [OFF_BITS-1:0]  off;
      logic [BYTE_BITS-1:0] bofs;
    } fld;
  } dcache_adr_u;

  // byte lanes touched by an aligned access
  function automatic logic [WORD_BYTES-1:0] size_to_be(input logic [1:0] size,
                                                       input logic [BYTE_BITS-1:0] bofs);
    logic [WORD_BYTES-1:0] be;
    case (size)
      SIZE_BYTE:  be = 4'b0001 << bofs;
      SIZE_HWORD: be = 4'b0011 << bofs;
      default:    be = 4'b1111;                        // word, offset is zero
    endcase
    return be;
  endfunction

endpackage

`default_nettype wire

//--- hw/dcache_tag_store.sv
/* tag store
   per-set tag array with valid and dirty flops, registered hit compare */
`default_nettype none

module dcache_tag_store (
  input  wire                                clk_i,
  input  wire                                rst_ni,
  input  wire  [dcache_pkg::IDX_BITS-1:0]    idx_i,       // set being looked up or written
  input  wire  [dcache_pkg::TAG_BITS-1:0]    tag_i,       // request tag
  input  wire                                we_i,        // fill, write tag and set valid
  input  wire                                dirty_i,     // dirty value loaded on fill
  input  wire                                set_dirty_i, // write hit
  output logic                               hit_o,
  output logic                               dirty_o,     // victim valid and dirty
  output logic [dcache_pkg::TAG_BITS-1:0]    tag_o        // stored tag, for victim address
);

  import dcache_pkg::*;

  logic [TAG_BITS-1:0] tag_mem [SETS];
  logic [SETS-1:0]     valid_q;
  logic [SETS-1:0]     dirty_q;

  // ------------------------------
  // state bits and lookup result
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      dirty_q <= '0;
      hit_o   <= 1'b0;
      dirty_o <= 1'b0;
    end else begin
      if (we_i) begin
        valid_q[idx_i] <= 1'b1;
        dirty_q[idx_i] <= dirty_i;    // write miss fills dirty
      end else if (set_dirty_i) begin
        dirty_q[idx_i] <= 1'b1;
      end
      // compare against the entry before this edge's update
      hit_o   <= valid_q[idx_i] & (tag_mem[idx_i] == tag_i);
      dirty_o <= valid_q[idx_i] & dirty_q[idx_i];
    end
  end

  // tag array
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      tag_mem[idx_i] <= tag_i;
    end
    tag_o <= tag_mem[idx_i];          // read first
  end

endmodule

`default_nettype wire

//--- hw/dcache_data_store.sv
/* data store
   line array with byte-enabled line writes, registered word and line reads */
`default_nettype none

module dcache_data_store (
  input  wire                                   clk_i,
  input  wire  [dcache_pkg::IDX_BITS-1:0]       idx_i,
  input  wire  [dcache_pkg::OFF_BITS-1:0]       off_i,   // word select for word_o
  input  wire  [dcache_pkg::LINE_BITS/8-1:0]    be_i,    // one bit per line byte
  input  wire  [dcache_pkg::LINE_BITS-1:0]      d_i,
  output logic [dcache_pkg::XLEN-1:0]           word_o,
  output logic [dcache_pkg::LINE_BITS-1:0]      line_o   // whole line, victim copy
);

  import dcache_pkg::*;

  logic [LINE_BITS-1:0] line_mem [SETS];

  // ------------------------------
  // write, byte granular
  // ------------------------------
  always_ff @(posedge clk_i) begin
    for (int b = 0; b < LINE_BYTES; b++) begin
      if (be_i[b]) begin
        line_mem[idx_i][b*8 +: 8] <= d_i[b*8 +: 8];
      end
    end
  end

  // ------------------------------
  // read, one cycle later
  // ------------------------------
  // returns the line as it was before a write at the same edge
  always_ff @(posedge clk_i) begin
    line_o <= line_mem[idx_i];
    word_o <= line_mem[idx_i][off_i*XLEN +: XLEN];
  end

endmodule

`default_nettype wire

//--- hw/dcache_ctrl.sv
/* cache controller
   answers hits, merges write data, sequences write-back and fill through the bus engine */
`default_nettype none

module dcache_ctrl (
  input  wire                                   clk_i,
  input  wire                                   rst_ni,
  // cpu port
  input  wire                                   req_i,
  input  wire                                   we_i,
  input  wire  [dcache_pkg::ADR_BITS-1:0]       adr_i,
  input  wire  [1:0]                            size_i,
  input  wire  [dcache_pkg::XLEN-1:0]           d_i,          // lane aligned
  output logic [dcache_pkg::XLEN-1:0]           q_o,
  output logic                                  ack_o,
  // tag store
  output logic [dcache_pkg::IDX_BITS-1:0]       idx_o,        // shared by both stores
  output logic [dcache_pkg::TAG_BITS-1:0]       tag_o,
  output logic                                  tag_we_o,
  output logic                                  tag_dirty_o,
  output logic                                  set_dirty_o,
  input  wire                                   hit_i,
  input  wire                                   victim_dirty_i,
  input  wire  [dcache_pkg::TAG_BITS-1:0]       victim_tag_i,
  // data store
  output logic [dcache_pkg::OFF_BITS-1:0]       dat_off_o,
  output logic [dcache_pkg::LINE_BITS/8-1:0]    dat_be_o,
  output logic [dcache_pkg::LINE_BITS-1:0]      dat_d_o,
  input  wire  [dcache_pkg::XLEN-1:0]           word_i,
  // bus engine
  output logic                                  cmd_rd_o,
  output logic                                  cmd_wr_o,
  output logic [dcache_pkg::ADR_BITS-1:0]       cmd_adr_o,
  input  wire                                   done_i,
  input  wire  [dcache_pkg::LINE_BITS-1:0]      fill_line_i
);

  import dcache_pkg::*;

  dcache_adr_u            req_adr;
  dcache_adr_u            fill_adr;      // line start of the request
  dcache_adr_u            vic_adr;       // line start of the victim
  logic [1:0]             state_q;
  logic                   lookup_q;      // stores hold this request's entry
  logic                   miss;
  logic                   fill_we;
  logic [WORD_BYTES-1:0]  word_be;
  logic [LINE_BYTES-1:0]  line_be;
  logic [LINE_BITS-1:0]   wr_line;
  logic [LINE_BITS-1:0]   merged_line;

  // ------------------------------
  // address decode
  // ------------------------------
  always_comb begin
    req_adr.raw      = adr_i;
    fill_adr.raw     = '0;
    fill_adr.fld.tag = req_adr.fld.tag;
    fill_adr.fld.idx = req_adr.fld.idx;
    vic_adr.raw      = '0;
    vic_adr.fld.tag  = victim_tag_i;     // rebuilt from the stored tag
    vic_adr.fld.idx  = req_adr.fld.idx;
  end

  assign word_be = size_to_be(size_i, req_adr.fld.bofs);
  assign line_be = LINE_BYTES'(word_be) << (req_adr.fld.off * WORD_BYTES);
  assign wr_line = {LINE_WORDS{d_i}};    // be picks the word

  // fill line with the write bytes laid over it
  always_comb begin
    for (int b = 0; b < LINE_BYTES; b++) begin
      merged_line[b*8 +: 8] = (we_i && line_be[b]) ? wr_line[b*8 +: 8]
                                                    : fill_line_i[b*8 +: 8];
    end
  end

  // ------------------------------
  // cpu answer and commands
  // ------------------------------
  assign ack_o     = (state_q == ARMED) & lookup_q & hit_i;
  assign miss      = (state_q == ARMED) & lookup_q & ~hit_i;
  assign q_o       = word_i;
  assign cmd_wr_o  = miss & victim_dirty_i;                   // line_o valid now
  assign cmd_rd_o  = (miss & ~victim_dirty_i) | ((state_q == WRITEBACK) & done_i);
  assign cmd_adr_o = cmd_wr_o ? vic_adr.raw : fill_adr.raw;

  // store controls, index always follows the held request
  assign fill_we     = (state_q == FILL) & done_i;
  assign idx_o       = req_adr.fld.idx;
  assign tag_o       = req_adr.fld.tag;
  assign dat_off_o   = req_adr.fld.off;
  assign tag_we_o    = fill_we;
  assign tag_dirty_o = we_i;                                  // write miss lands dirty
  assign set_dirty_o = ack_o & we_i;
  assign dat_be_o    = fill_we ? '1 : ((ack_o & we_i) ? line_be : '0);
  assign dat_d_o     = fill_we ? merged_line : wr_line;

  // ------------------------------
  // state machine
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= ARMED;
      lookup_q <= 1'b0;
    end else begin
      case (state_q)
        ARMED: begin
          lookup_q <= req_i & ~ack_o & ~miss;                 // next request after ack
          if (miss) state_q <= victim_dirty_i ? WRITEBACK : FILL;
        end
        WRITEBACK: begin
          lookup_q <= 1'b0;
          if (done_i) state_q <= FILL;                        // cmd_rd goes out now
        end
        FILL: begin
          lookup_q <= 1'b0;
          if (done_i) state_q <= RECOVER;
        end
        default: begin                                        // RECOVER
          lookup_q <= req_i;                                  // reread, then hit path acks
          state_q  <= ARMED;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/dcache_biu_fsm.sv
/* bus burst engine
   strobe handshake then LINE_WORDS beats, one line buffer for write-back and fill */
`default_nettype none

module dcache_biu_fsm (
  input  wire                                clk_i,
  input  wire                                rst_ni,
  // controller side
  input  wire                                cmd_rd_i,
  input  wire                                cmd_wr_i,
  input  wire  [dcache_pkg::ADR_BITS-1:0]    cmd_adr_i,     // line aligned
  input  wire  [dcache_pkg::LINE_BITS-1:0]   line_i,        // victim from data store
  output logic                               done_o,
  output logic [dcache_pkg::LINE_BITS-1:0]   fill_line_o,
  // bus side
  output logic                               biu_stb_o,
  output logic                               biu_we_o,
  output logic [dcache_pkg::ADR_BITS-1:0]    biu_adr_o,
  output logic [dcache_pkg::XLEN-1:0]        biu_d_o,
  input  wire                                biu_stb_ack_i,
  input  wire                                biu_d_ack_i,   // memory took biu_d_o
  input  wire  [dcache_pkg::XLEN-1:0]        biu_q_i,
  input  wire                                biu_ack_i      // beat done
);

  import dcache_pkg::*;

  logic [1:0]            state_q;
  logic [BURST_BITS-1:0] beat_q;
  logic [LINE_BITS-1:0]  line_q;       // shifts right, word 0 at the bottom
  logic                  start;
  logic                  last_beat;

  assign start     = (state_q == IDLE) & (cmd_rd_i | cmd_wr_i);
  assign last_beat = (state_q == BURST) & biu_ack_i
                   & (beat_q == BURST_BITS'(LINE_WORDS - 1));

  // ------------------------------
  // control
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      beat_q  <= '0;
      done_o  <= 1'b0;
    end else begin
      done_o <= last_beat;              // one cycle after last ack
      case (state_q)
        IDLE: if (start) state_q <= WAIT4BIU;
        WAIT4BIU: begin
          if (biu_stb_ack_i) begin
            state_q <= BURST;
            beat_q  <= '0;
          end
        end
        default: begin                  // BURST
          if (biu_ack_i) beat_q <= beat_q + 1'b1;
          if (last_beat) state_q <= IDLE;
        end
      endcase
    end
  end

  // ------------------------------
  // request and line buffer
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (start) begin
      biu_adr_o <= cmd_adr_i;
      biu_we_o  <= cmd_wr_i;
      if (cmd_wr_i) line_q <= line_i;   // copy victim in the command cycle
    end else if (state_q == BURST) begin
      if (biu_we_o && biu_d_ack_i) begin
        line_q <= {{XLEN{1'b0}}, line_q[LINE_BITS-1:XLEN]};   // next word out
      end else if (!biu_we_o && biu_ack_i) begin
        line_q <= {biu_q_i, line_q[LINE_BITS-1:XLEN]};        // beat in at the top
      end
    end
  end

  assign biu_stb_o   = (state_q == WAIT4BIU);
  assign biu_d_o     = line_q[XLEN-1:0];
  assign fill_line_o = line_q;          // complete when done_o is high

endmodule

`default_nettype wire

//--- hw/dcache.sv
/* write-back direct-mapped data cache, top level
   controller, tag and data stores and bus burst engine */
`default_nettype none

module dcache (
  input  wire                                clk_i,
  input  wire                                rst_ni,
  // cpu side
  input  wire                                req_i,
  input  wire                                we_i,
  input  wire  [dcache_pkg::ADR_BITS-1:0]    adr_i,
  input  wire  [1:0]                         size_i,
  input  wire  [dcache_pkg::XLEN-1:0]        d_i,
  output logic [dcache_pkg::XLEN-1:0]        q_o,
  output logic                               ack_o,
  // bus side
  output logic                               biu_stb_o,
  output logic                               biu_we_o,
  output logic [dcache_pkg::ADR_BITS-1:0]    biu_adr_o,
  output logic [dcache_pkg::XLEN-1:0]        biu_d_o,
  input  wire                                biu_stb_ack_i,
  input  wire                                biu_d_ack_i,
  input  wire  [dcache_pkg::XLEN-1:0]        biu_q_i,
  input  wire                                biu_ack_i
);

  import dcache_pkg::*;

  // ------------------------------
  // store links
  // ------------------------------
  logic [IDX_BITS-1:0]   idx;
  logic [TAG_BITS-1:0]   req_tag;
  logic                  tag_we;
  logic                  tag_dirty;
  logic                  set_dirty;
  logic                  hit;
  logic                  victim_dirty;
  logic [TAG_BITS-1:0]   victim_tag;
  logic [OFF_BITS-1:0]   dat_off;
  logic [LINE_BYTES-1:0] dat_be;
  logic [LINE_BITS-1:0]  dat_d;
  logic [XLEN-1:0]       dat_word;
  logic [LINE_BITS-1:0]  dat_line;

  // engine links
  logic                  cmd_rd;
  logic                  cmd_wr;
  logic [ADR_BITS-1:0]   cmd_adr;
  logic                  done;
  logic [LINE_BITS-1:0]  fill_line;

  dcache_ctrl i_ctrl (
    .clk_i, .rst_ni, .req_i, .we_i, .adr_i, .size_i, .d_i, .q_o, .ack_o,
    .idx_o          (idx),
    .tag_o          (req_tag),
    .tag_we_o       (tag_we),
    .tag_dirty_o    (tag_dirty),
    .set_dirty_o    (set_dirty),
    .hit_i          (hit),
    .victim_dirty_i (victim_dirty),
    .victim_tag_i   (victim_tag),
    .dat_off_o      (dat_off),
    .dat_be_o       (dat_be),
    .dat_d_o        (dat_d),
    .word_i         (dat_word),
    .cmd_rd_o       (cmd_rd),
    .cmd_wr_o       (cmd_wr),
    .cmd_adr_o      (cmd_adr),
    .done_i         (done),
    .fill_line_i    (fill_line)
  );

  dcache_tag_store i_tag (
    .clk_i, .rst_ni,
    .idx_i (idx), .tag_i (req_tag), .we_i (tag_we), .dirty_i (tag_dirty),
    .set_dirty_i (set_dirty), .hit_o (hit), .dirty_o (victim_dirty), .tag_o (victim_tag)
  );

  dcache_data_store i_data (
    .clk_i,
    .idx_i (idx), .off_i (dat_off), .be_i (dat_be), .d_i (dat_d),
    .word_o (dat_word), .line_o (dat_line)
  );

  dcache_biu_fsm i_biu (
    .clk_i, .rst_ni,
    .cmd_rd_i (cmd_rd), .cmd_wr_i (cmd_wr), .cmd_adr_i (cmd_adr), .line_i (dat_line),
    .done_o (done), .fill_line_o (fill_line),
    .biu_stb_o, .biu_we_o, .biu_adr_o, .biu_d_o,
    .biu_stb_ack_i, .biu_d_ack_i, .biu_q_i, .biu_ack_i
  );

endmodule

`default_nettype wire

//--- sim/tb_mem_model.sv
/* bus-side memory model
   answers strobe and beat handshakes after random stalls, keeps a word array */
`default_nettype none

module tb_mem_model (
  input  wire                              clk_i,
  input  wire                              stb_i,
  input  wire                              we_i,
  input  wire  [dcache_pkg::ADR_BITS-1:0]  adr_i,     // line aligned
  input  wire  [dcache_pkg::XLEN-1:0]      d_i,
  output logic                             stb_ack_o,
  output logic                             d_ack_o,
  output logic [dcache_pkg::XLEN-1:0]      q_o,
  output logic                             ack_o
);

  import dcache_pkg::*;

  localparam int MEM_WORDS = 2 ** (ADR_BITS - BYTE_BITS);
  localparam int DRIVE_DLY = 2;

  logic [XLEN-1:0] mem [MEM_WORDS];
  integer          seed;
  int              base_w;                 // first word of the burst
  logic            wr_burst;

  // low half w*3+1, upper half inverted word address
  function automatic logic [XLEN-1:0] init_word(input int w);
    logic [15:0] lo;
    lo = 16'(w * 3 + 1);
    return {~16'(w), lo};
  endfunction

  // outputs only move just after the rising edge
  task automatic next_cycle;
    @(posedge clk_i);
    #DRIVE_DLY;
  endtask

  // back-pressure, 0 to 3 cycles
  task automatic stall;
    int n;
    n = $unsigned($random(seed)) % 4;
    repeat (n) next_cycle;
  endtask

  // ------------------------------
  // burst responder
  // ------------------------------
  initial begin
    seed      = 92;
    stb_ack_o = 1'b0;
    d_ack_o   = 1'b0;
    ack_o     = 1'b0;
    q_o       = '0;
    for (int w = 0; w < MEM_WORDS; w++) mem[w] = init_word(w);
    forever begin
      next_cycle;
      if (stb_i === 1'b1) begin
        base_w   = int'(adr_i >> BYTE_BITS);
        wr_burst = we_i;
        stall;
        stb_ack_o = 1'b1;
        next_cycle;
        stb_ack_o = 1'b0;
        for (int n = 0; n < LINE_WORDS; n++) begin
          stall;
          ack_o = 1'b1;
          if (wr_burst) begin
            d_ack_o         = 1'b1;          // take the word shown now
            mem[base_w + n] = d_i;
          end else begin
            q_o = mem[base_w + n];
          end
          next_cycle;
          ack_o   = 1'b0;
          d_ack_o = 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- sim/tb_dcache.sv
/* data cache testbench
   table of cpu requests checked against a shadow memory and a tag model */
`default_nettype none

module tb_dcache;

  import dcache_pkg::*;

  localparam int CLK_PERIOD   = 20;
  localparam int DRIVE_DLY    = 2;
  localparam int RESET_CYCLES = 8;
  localparam int N_ENTRIES    = 16;
  localparam int MEM_WORDS    = 2 ** (ADR_BITS - BYTE_BITS);

  logic                clk_i;
  logic                rst_ni;
  logic                req_i;
  logic                we_i;
  logic [ADR_BITS-1:0] adr_i;
  logic [1:0]          size_i;
  logic [XLEN-1:0]     d_i;
  logic [XLEN-1:0]     q_o;
  logic                ack_o;
  logic                biu_stb_o;
  logic                biu_we_o;
  logic [ADR_BITS-1:0] biu_adr_o;
  logic [XLEN-1:0]     biu_d_o;
  logic                biu_stb_ack_i;
  logic                biu_d_ack_i;
  logic [XLEN-1:0]     biu_q_i;
  logic                biu_ack_i;

  // stimulus table and expected results
  logic                 tab_we       [N_ENTRIES];
  logic [ADR_BITS-1:0]  tab_adr      [N_ENTRIES];
  logic [1:0]           tab_size     [N_ENTRIES];
  logic [XLEN-1:0]      tab_wdata    [N_ENTRIES];   // lane aligned
  logic [XLEN-1:0]      exp_q        [N_ENTRIES];
  logic                 exp_hit      [N_ENTRIES];
  logic [ADR_BITS-1:0]  exp_fill_adr [N_ENTRIES];
  logic                 exp_wb       [N_ENTRIES];
  logic [ADR_BITS-1:0]  exp_wb_adr   [N_ENTRIES];
  logic [LINE_BITS-1:0] exp_wb_line  [N_ENTRIES];
  int                   n_tab;

  // shadow memory and direct-mapped tag model
  logic [XLEN-1:0]      shadow  [MEM_WORDS];
  logic                 c_valid [SETS];
  logic                 c_dirty [SETS];
  logic [TAG_BITS-1:0]  c_tag   [SETS];

  // bus monitor counts cleared per entry
  int                   rd_bursts;
  int                   wr_bursts;
  int                   wb_beats;
  logic [ADR_BITS-1:0]  rd_adr_seen;
  logic [ADR_BITS-1:0]  wr_adr_seen;
  logic [LINE_BITS-1:0] wb_line_seen;

  int                   n_mismatch;
  int                   n_other;

  dcache i_dut (
    .clk_i, .rst_ni, .req_i, .we_i, .adr_i, .size_i, .d_i, .q_o, .ack_o,
    .biu_stb_o, .biu_we_o, .biu_adr_o, .biu_d_o,
    .biu_stb_ack_i, .biu_d_ack_i, .biu_q_i, .biu_ack_i
  );

  tb_mem_model i_mem (
    .clk_i     (clk_i),
    .stb_i     (biu_stb_o),
    .we_i      (biu_we_o),
    .adr_i     (biu_adr_o),
    .d_i       (biu_d_o),
    .stb_ack_o (biu_stb_ack_i),
    .d_ack_o   (biu_d_ack_i),
    .q_o       (biu_q_i),
    .ack_o     (biu_ack_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // ------------------------------
  // reference rules
  // ------------------------------
  function automatic logic [XLEN-1:0] init_word(input int w);
    logic [15:0] lo;
    lo = 16'(w * 3 + 1);
    return {~16'(w), lo};
  endfunction

  // lanes covered by an access of 1, 2 or 4 bytes starting at bofs
  function automatic logic [3:0] lane_mask(input logic [1:0] size, input logic [1:0] bofs);
    int         nbytes;
    logic [3:0] mask;
    nbytes = 1 << size;
    mask   = '0;
    for (int b = 0; b < 4; b++) begin
      if (b >= int'(bofs) && b < int'(bofs) + nbytes) mask[b] = 1'b1;
    end
    return mask;
  endfunction

  function automatic logic [XLEN-1:0] merge_word(input logic [XLEN-1:0] old_w,
                                                 input logic [XLEN-1:0] new_w,
                                                 input logic [3:0]      mask);
    logic [XLEN-1:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) res[b*8 +: 8] = new_w[b*8 +: 8];
    end
    return res;
  endfunction

  task automatic add_entry(input logic we, input logic [ADR_BITS-1:0] adr,
                           input logic [1:0] size, input logic [XLEN-1:0] wdata);
    tab_we[n_tab]    = we;
    tab_adr[n_tab]   = adr;
    tab_size[n_tab]  = size;
    tab_wdata[n_tab] = wdata;
    n_tab++;
  endtask

  // walk the table once to predict hits, bursts and data
  task automatic build_expected;
    dcache_adr_u a;
    dcache_adr_u v;
    int          w;
    for (int m = 0; m < MEM_WORDS; m++) shadow[m] = init_word(m);
    for (int s = 0; s < SETS; s++) begin
      c_valid[s] = 1'b0;
      c_dirty[s] = 1'b0;
      c_tag[s]   = '0;
    end
    for (int i = 0; i < n_tab; i++) begin
      a.raw           = tab_adr[i];
      w               = int'(tab_adr[i] >> BYTE_BITS);
      exp_hit[i]      = c_valid[a.fld.idx] && (c_tag[a.fld.idx] == a.fld.tag);
      exp_wb[i]       = !exp_hit[i] && c_valid[a.fld.idx] && c_dirty[a.fld.idx];
      exp_fill_adr[i] = tab_adr[i] & ~ADR_BITS'(LINE_BYTES - 1);
      v.raw           = '0;
      v.fld.tag       = c_tag[a.fld.idx];                // victim line start
      v.fld.idx       = a.fld.idx;
      exp_wb_adr[i]   = v.raw;
      for (int n = 0; n < LINE_WORDS; n++) begin
        exp_wb_line[i][n*XLEN +: XLEN] = shadow[int'(v.raw >> BYTE_BITS) + n];
      end
      if (!exp_hit[i]) begin
        c_valid[a.fld.idx] = 1'b1;                       // line refilled clean
        c_tag[a.fld.idx]   = a.fld.tag;
        c_dirty[a.fld.idx] = 1'b0;
      end
      if (tab_we[i]) begin
        shadow[w]          = merge_word(shadow[w], tab_wdata[i],
                                        lane_mask(tab_size[i], a.fld.bofs));
        c_dirty[a.fld.idx] = 1'b1;
      end
      exp_q[i] = shadow[w];
    end
  endtask

  // ------------------------------
  // bus monitor sampling mid-cycle
  // ------------------------------
  always @(negedge clk_i) begin
    if (biu_stb_o && biu_stb_ack_i) begin
      if (biu_we_o) begin
        wr_bursts++;
        wr_adr_seen = biu_adr_o;
      end else begin
        rd_bursts++;
        rd_adr_seen = biu_adr_o;
      end
    end
    if (biu_d_ack_i) begin
      if (wb_beats < LINE_WORDS) wb_line_seen[wb_beats*XLEN +: XLEN] = biu_d_o;
      wb_beats++;
    end
  end

  task automatic check_quiet(input string when);
    if (ack_o !== 1'b0 || biu_stb_o !== 1'b0) begin
      $display("mismatch at %0t: ack_o %b biu_stb_o %b %s, expected both low",
               $time, ack_o, biu_stb_o, when);
      n_mismatch++;
    end
  endtask

  // one request held until ack_o and then checked
  task automatic run_entry(input int i);
    int              cycles;
    logic            seen;
    logic [XLEN-1:0] rdata;
    rd_bursts = 0;
    wr_bursts = 0;
    wb_beats  = 0;
    req_i  = 1'b1;
    we_i   = tab_we[i];
    adr_i  = tab_adr[i];
    size_i = tab_size[i];
    d_i    = tab_wdata[i];
    cycles = 0;
    seen   = 1'b0;
    while (!seen) begin
      @(negedge clk_i);
      if (ack_o) seen = 1'b1;
      else cycles++;
    end
    rdata = q_o;
    @(posedge clk_i);                // write hit lands as the ack cycle ends
    #DRIVE_DLY;
    req_i = 1'b0;
    we_i  = 1'b0;
    if (!tab_we[i] && rdata !== exp_q[i]) begin
      $display("mismatch at %0t: entry %0d q_o %h, expected %h", $time, i, rdata, exp_q[i]);
      n_mismatch++;
    end
    if (exp_hit[i]) begin
      if (rd_bursts != 0 || wr_bursts != 0) begin
        $display("entry %0d should hit but the bus saw %0d read and %0d write bursts",
                 i, rd_bursts, wr_bursts);
        n_other++;
      end
      if (cycles != 1) begin
        $display("mismatch at %0t: entry %0d hit latency %0d, expected 1", $time, i, cycles);
        n_mismatch++;
      end
    end else begin
      if (rd_bursts != 1 || wr_bursts != int'(exp_wb[i])) begin
        $display("entry %0d saw %0d read and %0d write bursts, expected 1 and %0d",
                 i, rd_bursts, wr_bursts, exp_wb[i]);
        n_other++;
      end else if (rd_adr_seen !== exp_fill_adr[i]) begin
        $display("mismatch at %0t: entry %0d fill address %h, expected %h",
                 $time, i, rd_adr_seen, exp_fill_adr[i]);
        n_mismatch++;
      end
      if (exp_wb[i] && wr_bursts == 1) begin
        if (wb_beats != LINE_WORDS) begin
          $display("entry %0d write-back moved %0d words instead of a full line", i, wb_beats);
          n_other++;
        end else if (wr_adr_seen !== exp_wb_adr[i] || wb_line_seen !== exp_wb_line[i]) begin
          $display("mismatch at %0t: entry %0d write-back %h %h, expected %h %h", $time, i,
                   wr_adr_seen, wb_line_seen, exp_wb_adr[i], exp_wb_line[i]);
          n_mismatch++;
        end
      end
    end
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    rst_ni     = 1'b0;
    req_i      = 1'b0;
    we_i       = 1'b0;
    adr_i      = '0;
    size_i     = SIZE_WORD;
    d_i        = '0;
    n_tab      = 0;
    n_mismatch = 0;
    n_other    = 0;
    add_entry(1'b0, 16'h1234, SIZE_WORD,  32'h0);           // cold read miss in set 3
    add_entry(1'b0, 16'h1238, SIZE_WORD,  32'h0);           // hit in the same line
    add_entry(1'b1, 16'h1235, SIZE_BYTE,  32'h0000_ab00);   // byte lane 1
    add_entry(1'b1, 16'h1236, SIZE_HWORD, 32'hcdef_0000);   // upper half
    add_entry(1'b0, 16'h1234, SIZE_WORD,  32'h0);           // merged word back
    add_entry(1'b1, 16'h2340, SIZE_WORD,  32'hdead_beef);   // write miss in set 4
    add_entry(1'b0, 16'h234c, SIZE_WORD,  32'h0);           // rest of line from memory
    add_entry(1'b0, 16'h2340, SIZE_WORD,  32'h0);
    add_entry(1'b0, 16'h5537, SIZE_BYTE,  32'h0);           // evicts dirty 0x1230
    add_entry(1'b0, 16'h1234, SIZE_WORD,  32'h0);           // refill after write-back
    add_entry(1'b1, 16'h1232, SIZE_HWORD, 32'h7766_0000);
    add_entry(1'b1, 16'h2341, SIZE_BYTE,  32'h0000_5a00);
    add_entry(1'b0, 16'h9944, SIZE_WORD,  32'h0);           // evicts dirty 0x2340
    add_entry(1'b0, 16'h2340, SIZE_WORD,  32'h0);
    add_entry(1'b0, 16'h1233, SIZE_BYTE,  32'h0);
    add_entry(1'b1, 16'h12f0, SIZE_WORD,  32'h1357_2468);   // write miss into empty set 15
    build_expected;
    repeat (RESET_CYCLES) begin
      @(posedge clk_i);
      #DRIVE_DLY;
      check_quiet("during reset");
    end
    rst_ni = 1'b1;
    repeat (2) begin
      @(posedge clk_i);
      #DRIVE_DLY;
      check_quiet("after reset");
    end
    for (int i = 0; i < n_tab; i++) run_entry(i);
    $display("entries %0d, mismatches %0d, other errors %0d", n_tab, n_mismatch, n_other);
    if (n_mismatch == 0 && n_other == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // watchdog allows 200 cycles per entry
  initial begin
    #(N_ENTRIES * 200 * CLK_PERIOD);
    $display("timeout, a request was not acknowledged within %0d cycles", N_ENTRIES * 200);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- dcache.f
hw/dcache_pkg.sv
hw/dcache_tag_store.sv
hw/dcache_data_store.sv
hw/dcache_ctrl.sv
hw/dcache_biu_fsm.sv
hw/dcache.sv
sim/tb_mem_model.sv
sim/tb_dcache.sv
